//--- acs/acs_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "viterbi_cfg.svh"

module acs_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   bm_valid,
    input  viterbi_pkg::bm_t       bm_00,
    input  viterbi_pkg::bm_t       bm_01,
    input  viterbi_pkg::bm_t       bm_10,
    input  viterbi_pkg::bm_t       bm_11,
    output logic                   dec_valid,
    output viterbi_pkg::decision_t decisions,
    output viterbi_pkg::state_t    best_state
);

    // Encoder output for a 3-bit register window
    // Window is {input bit, newer state bit, older state bit}
    function automatic viterbi_pkg::symbol_t code_pair(input logic [2:0] window);
        return {^(window & `VIT_GEN0), ^(window & `VIT_GEN1)};
    endfunction

    // Stored metrics, one per state
    viterbi_pkg::metric_t metric [`VIT_NUM_STATES];

    // Branch metrics indexed by code pair value
    viterbi_pkg::bm_t bm_tab [4];

    // Candidate sums carry one extra bit before renormalization
    logic [`VIT_METRIC_W:0] sum_lo   [`VIT_NUM_STATES];
    logic [`VIT_METRIC_W:0] sum_hi   [`VIT_NUM_STATES];
    logic [`VIT_METRIC_W:0] new_metric [`VIT_NUM_STATES];

    viterbi_pkg::decision_t new_dec;
    viterbi_pkg::state_t    min_state;

    //////////////////////////////
    // Add and compare
    //////////////////////////////

    always_comb begin
        viterbi_pkg::state_t nxt;
        viterbi_pkg::state_t pred_lo;
        viterbi_pkg::state_t pred_hi;

        bm_tab[0] = bm_00;
        bm_tab[1] = bm_01;
        bm_tab[2] = bm_10;
        bm_tab[3] = bm_11;

        for (int n = 0; n < `VIT_NUM_STATES; n++) begin
            nxt = viterbi_pkg::state_t'(n);
            // Both predecessors share the newer bit, which is now nxt[0]
            pred_lo = {nxt[0], 1'b0};
            pred_hi = {nxt[0], 1'b1};
            // Input bit of this transition is nxt[1]
            sum_lo[n] = {1'b0, metric[pred_lo]}
                      + {{(`VIT_METRIC_W-1){1'b0}}, bm_tab[code_pair({nxt, 1'b0})]};
            sum_hi[n] = {1'b0, metric[pred_hi]}
                      + {{(`VIT_METRIC_W-1){1'b0}}, bm_tab[code_pair({nxt, 1'b1})]};
            // Strict compare, a tie keeps the predecessor with oldest bit 0
            new_dec[n]    = (sum_hi[n] < sum_lo[n]);
            new_metric[n] = new_dec[n] ? sum_hi[n] : sum_lo[n];
        end
    end

    //////////////////////////////
    // Best state search
    //////////////////////////////

    // Lowest index wins on equal metrics
    always_comb begin
        min_state = '0;
        for (int n = 1; n < `VIT_NUM_STATES; n++) begin
            if (new_metric[n] < new_metric[min_state]) begin
                min_state = viterbi_pkg::state_t'(n);
            end
        end
    end

    //////////////////////////////
    // Select and renormalize
    //////////////////////////////

    // Metrics restart with state 0 favoured after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            for (int n = 0; n < `VIT_NUM_STATES; n++) begin
                metric[n] <= (n == 0) ? '0 : viterbi_pkg::metric_t'(`VIT_INIT_METRIC);
            end
        end else begin
            dec_valid <= bm_valid;
            if (bm_valid) begin
                // Smallest metric becomes 0, spread stays well inside VIT_METRIC_W
                for (int n = 0; n < `VIT_NUM_STATES; n++) begin
                    metric[n] <= viterbi_pkg::metric_t'(new_metric[n]
                                                        - new_metric[min_state]);
                end
            end
        end
    end

    // Survivor payload for the traceback stage
    always_ff @(posedge clk) begin
        if (bm_valid) begin
            decisions  <= new_dec;
            best_state <= min_state;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_viterbi.sv
`default_nettype none
`timescale 1ns/100ps

`include "viterbi_cfg.svh"

module tb_viterbi;

    localparam int NUM_TESTS    = 6;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int MODE_ZEROS   = 0;
    localparam int MODE_ONES    = 1;
    localparam int MODE_RANDOM  = 2;

    //////////////////////////////
    // Test table
    //////////////////////////////

    string test_names [NUM_TESTS];
    int    test_bits  [NUM_TESTS];
    int    test_mode  [NUM_TESTS];
    // Symbols between single flipped code bits, 0 for a clean channel
    int    err_space  [NUM_TESTS];
    int    max_gap    [NUM_TESTS];
    logic  table_loaded = 1'b0;

    logic                 clk = 1'b0;
    logic                 rst_n = 1'b0;
    logic                 in_valid = 1'b0;
    viterbi_pkg::symbol_t in_symbol = '0;
    logic                 out_valid;
    logic                 out_bit;
    logic [31:0]          rng = 32'h5966_e0fb;

    always #(CLK_PERIOD / 2) clk = ~clk;

    viterbi_decoder viterbi_decoder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_symbol (in_symbol),
        .out_valid (out_valid),
        .out_bit   (out_bit)
    );

    viterbi_scoreboard scoreboard (
        .clk       (clk),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .out_bit   (out_bit)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Reference encoder, register holds {newest input .. oldest}
    function automatic viterbi_pkg::symbol_t encode_pair(input logic [2:0] sreg);
        logic [2:0]           g0;
        logic [2:0]           g1;
        viterbi_pkg::symbol_t pair;
        g0   = `VIT_GEN0;
        g1   = `VIT_GEN1;
        pair = '0;
        for (int t = 0; t < 3; t++) begin
            pair[1] = pair[1] ^ (g0[t] & sreg[t]);
            pair[0] = pair[0] ^ (g1[t] & sreg[t]);
        end
        return pair;
    endfunction

    task automatic set_row(input int i, input string name, input int bits, input int mode,
                           input int space, input int gap);
        test_names[i] = name;
        test_bits[i]  = bits;
        test_mode[i]  = mode;
        err_space[i]  = space;
        max_gap[i]    = gap;
    endtask

    task automatic load_table();
        set_row(0, "all_zeros",  40,  MODE_ZEROS,  0,  0);
        set_row(1, "all_ones",   40,  MODE_ONES,   0,  0);
        set_row(2, "random",     200, MODE_RANDOM, 0,  0);
        set_row(3, "random_err", 240, MODE_RANDOM, 16, 0);
        set_row(4, "random_gap", 160, MODE_RANDOM, 0,  3);
        set_row(5, "err_gap",    200, MODE_RANDOM, 20, 4);
        table_loaded = 1'b1;
    endtask

    // Worst case run time of the whole table in ns
    function automatic longint watchdog_ns();
        longint total;
        total = NUM_TESTS * RESET_CYCLES * CLK_PERIOD;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total += (test_bits[i] * (max_gap[i] + 1) + 20) * CLK_PERIOD;
        end
        return total;
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic run_test(input int idx);
        logic [2:0]           sreg;
        viterbi_pkg::symbol_t code;
        logic                 u;
        int                   gap;
        int                   waited;
        // Decoder has to restart from state 0
        rst_n    = 1'b0;
        in_valid = 1'b0;
        scoreboard.start_test(test_names[idx], test_bits[idx]);
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        sreg  = '0;
        for (int i = 0; i < test_bits[idx]; i++) begin
            u = (test_mode[idx] == MODE_ONES);
            if (test_mode[idx] == MODE_RANDOM) begin
                rng = xorshift(rng);
                u   = rng[31];
            end
            sreg = {u, sreg[2:1]};
            code = encode_pair(sreg);
            // Single channel error in the middle of each spacing interval
            if (err_space[idx] != 0 && (i % err_space[idx]) == err_space[idx] / 2) begin
                rng = xorshift(rng);
                code[rng[0]] = ~code[rng[0]];
            end
            scoreboard.push_expected(u);
            gap = 0;
            if (max_gap[idx] != 0) begin
                rng = xorshift(rng);
                gap = int'(rng % (max_gap[idx] + 1));
            end
            repeat (gap) @(negedge clk);
            in_valid  = 1'b1;
            in_symbol = code;
            @(negedge clk);
            in_valid = 1'b0;
        end
        // Last decoded bit trails the last symbol by the pipeline latency
        waited = 0;
        while (scoreboard.out_count < test_bits[idx] - (`VIT_TB_DEPTH - 1)
               && waited < 4 * `VIT_STAGE_LAT) begin
            @(negedge clk);
            waited++;
        end
        repeat (`VIT_STAGE_LAT + 1) @(negedge clk);
        scoreboard.end_test();
    endtask

    initial begin
        load_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests run %0d, failed %0d, bit mismatches %0d, assertion failures %0d",
                 scoreboard.tests_run, scoreboard.tests_failed, scoreboard.mismatches,
                 viterbi_decoder_i.viterbi_checker_i.fail_count);
        if (scoreboard.tests_failed == 0
            && viterbi_decoder_i.viterbi_checker_i.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        longint limit_ns;
        wait (table_loaded);
        limit_ns = watchdog_ns();
        #(limit_ns);
        $display("Timeout: the tests did not finish within %0d ns", limit_ns);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/viterbi_checker.sv
`default_nettype none
`timescale 1ns/100ps

`include "viterbi_cfg.svh"

module viterbi_checker (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic out_bit
);

    // Strobes accepted since reset, saturating at the window length
    int in_seen;
    // Assertion failures seen so far
    int fail_count = 0;

    always @(posedge clk) begin
        if (!rst_n) begin
            in_seen <= 0;
        end else if (in_valid && in_seen < `VIT_TB_DEPTH) begin
            in_seen <= in_seen + 1;
        end
    end

    //////////////////////////////
    // Handshake timing
    //////////////////////////////

    // Window full, so every strobe comes out after the pipeline latency
    a_out_after_in: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_seen >= `VIT_TB_DEPTH - 1 |-> ##(`VIT_STAGE_LAT) out_valid)
        else begin
            $error("out_valid missing %0d cycles after in_valid", `VIT_STAGE_LAT);
            fail_count++;
        end

    // No output strobe without a matching input strobe
    a_no_stray_out: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, `VIT_STAGE_LAT))
        else begin
            $error("out_valid without in_valid %0d cycles earlier", `VIT_STAGE_LAT);
            fail_count++;
        end

    // Synchronous reset clears the output strobe
    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_count++;
        end

    a_known_bit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(out_bit))
        else begin
            $error("out_bit unknown while out_valid is high");
            fail_count++;
        end

endmodule

bind viterbi_decoder viterbi_checker viterbi_checker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_bit   (out_bit)
);

`default_nettype wire

//--- bench/viterbi_scoreboard.sv
`default_nettype none
`timescale 1ns/100ps

`include "viterbi_cfg.svh"

module viterbi_scoreboard (
    input logic clk,
    input logic in_valid,
    input logic out_valid,
    input logic out_bit
);

    // Expected decoded bits of the running test, oldest first
    logic exp_q [$];

    string test_name;
    int    test_bits;
    int    in_count;
    int    out_count;
    int    test_errors;

    // Strobe count at each of the latest rising edges, newest first
    int    cnt_hist [`VIT_STAGE_LAT];

    // Totals over the whole run
    int tests_run = 0;
    int tests_failed = 0;
    int mismatches = 0;

    task automatic start_test(input string name, input int bits);
        test_name   = name;
        test_bits   = bits;
        in_count    = 0;
        out_count   = 0;
        test_errors = 0;
        foreach (cnt_hist[i]) begin
            cnt_hist[i] = 0;
        end
        exp_q.delete();
    endtask

    task automatic push_expected(input logic b);
        exp_q.push_back(b);
    endtask

    // Inputs change on the falling edge and are stable at the rising edge
    always @(posedge clk) begin
        if (in_valid) begin
            in_count++;
        end
        for (int i = `VIT_STAGE_LAT - 1; i > 0; i--) begin
            cnt_hist[i] = cnt_hist[i-1];
        end
        cnt_hist[0] = in_count;
    end

    //////////////////////////////
    // Output compare
    //////////////////////////////

    // Oldest history entry counts the strobes up to the one this output belongs to
    always @(negedge clk) begin
        logic exp_bit;
        if (out_valid) begin
            out_count++;
            if (cnt_hist[`VIT_STAGE_LAT-1] < `VIT_TB_DEPTH) begin
                $display("Error at %0t: output came before the survivor window filled", $time);
                test_errors++;
            end else if (exp_q.size() == 0) begin
                $display("Error at %0t: output came with no expected bit left", $time);
                test_errors++;
            end else begin
                exp_bit = exp_q.pop_front();
                if (out_bit !== exp_bit) begin
                    $display("FAIL at %0t: out_bit expected %0b actual %0b",
                             $time, exp_bit, out_bit);
                    test_errors++;
                    mismatches++;
                end
            end
        end
    end

    // One line per test
    // N symbols give N - 14 decoded bits
    task automatic end_test();
        int exp_out;
        exp_out = test_bits - (`VIT_TB_DEPTH - 1);
        if (out_count != exp_out) begin
            $display("Error: test %s gave %0d output bits instead of %0d",
                     test_name, out_count, exp_out);
            test_errors++;
        end
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %-12s %4d symbols %4d outputs %0d errors: %s", test_name, test_bits,
                 out_count, test_errors, (test_errors == 0) ? "ok" : "failed");
    endtask

endmodule

`default_nettype wire

//--- common/viterbi_cfg.svh
`ifndef VITERBI_CFG_SVH
`define VITERBI_CFG_SVH

//////////////////////////////
// Code definition
//////////////////////////////

// Rate 1/2, K = 3 code, generators 7 and 5 octal
// Bit 2 of a generator taps the newest input bit, bit 0 the oldest
`define VIT_GEN0 3'b111
`define VIT_GEN1 3'b101

//////////////////////////////
// Decoder sizing
//////////////////////////////

// Four trellis states for two memory bits
`define VIT_NUM_STATES 4
// Renormalized state metric width
`define VIT_METRIC_W 5
// Survivor window length in steps
`define VIT_TB_DEPTH 15
// Starting metric of states 1 to 3, so decoding starts at state 0
`define VIT_INIT_METRIC 8
// Input strobe to output strobe, one cycle per stage
`define VIT_STAGE_LAT 3

`endif

//--- common/viterbi_pkg.sv
`default_nettype none

`include "viterbi_cfg.svh"

package viterbi_pkg;

    //////////////////////////////
    // Channel side
    //////////////////////////////

    // Received code pair
    // Bit 1 carries the VIT_GEN0 output, bit 0 the VIT_GEN1 output
    typedef logic [1:0] symbol_t;

    // Hamming distance between two code pairs, 0 to 2
    typedef logic [1:0] bm_t;

    //////////////////////////////
    // Trellis side
    //////////////////////////////

    // Path metric, kept small by per-step renormalization
    typedef logic [`VIT_METRIC_W-1:0] metric_t;

    // Two most recent input bits
    // Bit 1 is the newest input, bit 0 the older one
    typedef logic [1:0] state_t;

    // One survivor bit per state
    // Each bit is the oldest bit of the winning predecessor
    typedef logic [`VIT_NUM_STATES-1:0] decision_t;

    // Survivor memory address, 0 to VIT_TB_DEPTH-1
    typedef logic [3:0] ptr_t;

endpackage

`default_nettype wire

//--- files.f
+incdir+common
common/viterbi_pkg.sv
rtl/branch_metric_unit.sv
acs/acs_unit.sv
traceback/survivor_traceback.sv
rtl/viterbi_decoder.sv
bench/viterbi_checker.sv
bench/viterbi_scoreboard.sv
bench/tb_viterbi.sv

//--- rtl/branch_metric_unit.sv
`default_nettype none
`timescale 1ns/100ps

module branch_metric_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  viterbi_pkg::symbol_t in_symbol,
    output logic                 bm_valid,
    output viterbi_pkg::bm_t     bm_00,
    output viterbi_pkg::bm_t     bm_01,
    output viterbi_pkg::bm_t     bm_10,
    output viterbi_pkg::bm_t     bm_11
);

    // Number of bit positions where the two pairs differ
    function automatic viterbi_pkg::bm_t hamming(
        input viterbi_pkg::symbol_t rx,
        input viterbi_pkg::symbol_t ref_pair
    );
        viterbi_pkg::symbol_t diff;
        diff = rx ^ ref_pair;
        return {1'b0, diff[1]} + {1'b0, diff[0]};
    endfunction

    //////////////////////////////
    // Strobe delay
    //////////////////////////////

    // Metrics below are valid one cycle after the input strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bm_valid <= 1'b0;
        end else begin
            bm_valid <= in_valid;
        end
    end

    //////////////////////////////
    // Distance registers
    //////////////////////////////

    // One distance per possible code pair
    // Held between strobes, so idle gaps leave them unchanged
    always_ff @(posedge clk) begin
        if (in_valid) begin
            bm_00 <= hamming(in_symbol, 2'b00);
            bm_01 <= hamming(in_symbol, 2'b01);
            bm_10 <= hamming(in_symbol, 2'b10);
            bm_11 <= hamming(in_symbol, 2'b11);
        end
    end

endmodule

`default_nettype wire

//--- rtl/viterbi_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module viterbi_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  viterbi_pkg::symbol_t in_symbol,
    output logic                 out_valid,
    output logic                 out_bit
);

    //////////////////////////////
    // Stage wires
    //////////////////////////////

    // Branch metric to ACS
    logic             bm_valid;
    viterbi_pkg::bm_t bm_00;
    viterbi_pkg::bm_t bm_01;
    viterbi_pkg::bm_t bm_10;
    viterbi_pkg::bm_t bm_11;

    // ACS to traceback
    logic                   dec_valid;
    viterbi_pkg::decision_t decisions;
    viterbi_pkg::state_t    best_state;

    //////////////////////////////
    // Pipeline, one cycle per stage
    //////////////////////////////

    branch_metric_unit branch_metric_unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_symbol (in_symbol),
        .bm_valid  (bm_valid),
        .bm_00     (bm_00),
        .bm_01     (bm_01),
        .bm_10     (bm_10),
        .bm_11     (bm_11)
    );

    acs_unit acs_unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .bm_valid   (bm_valid),
        .bm_00      (bm_00),
        .bm_01      (bm_01),
        .bm_10      (bm_10),
        .bm_11      (bm_11),
        .dec_valid  (dec_valid),
        .decisions  (decisions),
        .best_state (best_state)
    );

    survivor_traceback survivor_traceback_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_valid  (dec_valid),
        .decisions  (decisions),
        .best_state (best_state),
        .out_valid  (out_valid),
        .out_bit    (out_bit)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the Viterbi testbench with Verilator and run it
# The run fails when the log holds the fail message or lacks the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_viterbi \
    -f files.f -o tb_viterbi > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/tb_viterbi +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "TB FAILED" sim.log && exit 1 || grep -q "TB PASSED" sim.log

//--- traceback/survivor_traceback.sv
`default_nettype none
`timescale 1ns/100ps

`include "viterbi_cfg.svh"

module survivor_traceback (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dec_valid,
    input  viterbi_pkg::decision_t decisions,
    input  viterbi_pkg::state_t    best_state,
    output logic                   out_valid,
    output logic                   out_bit
);

    // Circular survivor store, one decision vector per step
    viterbi_pkg::decision_t dec_mem [`VIT_TB_DEPTH];

    // Address of the next write
    viterbi_pkg::ptr_t wr_ptr;
    // Vectors written since reset, saturating at VIT_TB_DEPTH
    viterbi_pkg::ptr_t fill_cnt;

    logic                window_full;
    viterbi_pkg::state_t trace_state;

    // This strobe completes the window when 14 vectors are already stored
    assign window_full = (fill_cnt >= viterbi_pkg::ptr_t'(`VIT_TB_DEPTH - 1));

    //////////////////////////////
    // Write side
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            fill_cnt <= '0;
        end else if (dec_valid) begin
            if (wr_ptr == viterbi_pkg::ptr_t'(`VIT_TB_DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fill_cnt != viterbi_pkg::ptr_t'(`VIT_TB_DEPTH)) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            dec_mem[wr_ptr] <= decisions;
        end
    end

    //////////////////////////////
    // Traceback walk
    //////////////////////////////

    // Step 0 uses the incoming vector, it is not in memory yet
    // Step k reads the vector written k strobes earlier
    always_comb begin
        viterbi_pkg::decision_t dvec;
        int                     idx;

        trace_state = best_state;
        for (int k = 0; k < `VIT_TB_DEPTH - 1; k++) begin
            if (k == 0) begin
                dvec = decisions;
            end else begin
                // Wrap backwards around the circular store
                idx = int'(wr_ptr) - k;
                if (idx < 0) begin
                    idx = idx + `VIT_TB_DEPTH;
                end
                dvec = dec_mem[idx];
            end
            // Predecessor keeps the older bit as its newest, decision as its oldest
            trace_state = {trace_state[0], dvec[trace_state]};
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= dec_valid && window_full;
        end
    end

    // Newest bit of the state 14 steps back is the decoded input
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            out_bit <= trace_state[1];
        end
    end

endmodule

`default_nettype wire
